/* hw/sw_params.svh */
`ifndef SW_PARAMS_SVH
`define SW_PARAMS_SVH

// one query base per element
`define SW_PE_COUNT 8
`define SW_QUERY_W (2 * `SW_PE_COUNT)

`define SW_SCORE_W 14
`define SW_POS_W 10

// linear part of the affine gap is charged on every gap base
`define SW_MATCH 2
`define SW_MISMATCH (-3)
`define SW_GAP_OPEN (-12)
`define SW_GAP_EXTEND (-1)

`define SW_XDROP 40

// top two bits set to leave headroom for extend and x-drop subtraction
`define SW_NEG_INF (-(1 << (`SW_SCORE_W - 2)))

`endif

/* hw/sw_pkg.sv */
`include "sw_params.svh"

package sw_pkg;

    typedef logic signed [`SW_SCORE_W-1:0] score_t;

    // any fixed mapping of A/C/G/T to 0..3
    typedef logic [1:0] base_t;

    typedef logic [`SW_POS_W-1:0] pos_t;

    typedef enum logic [1:0] {
        IDLE,
        CALC,
        DONE
    } stripe_state_t;

endpackage

/* hw/sw_link_if.sv */
`timescale 1ns/1ps

// carries the cell above the receiving element
interface sw_link_if import sw_pkg::*; ();
    base_t  base;
    logic   valid;
    score_t h;
    score_t f;

    modport src (
        output base,
        output valid,
        output h,
        output f
    );

    modport dst (
        input base,
        input valid,
        input h,
        input f
    );
endinterface

/* hw/sw_pe.sv */
`timescale 1ns/1ps
`include "sw_params.svh"

module sw_pe import sw_pkg::*; (
    input  logic   i_clk,
    input  logic   i_rst,
    input  base_t  i_query_base,
    input  score_t i_left_h,
    input  score_t i_left_e,
    sw_link_if.dst link_in,
    sw_link_if.src link_out
);
    localparam score_t OPEN_EXT = score_t'(`SW_GAP_OPEN + `SW_GAP_EXTEND);
    localparam score_t EXT = score_t'(`SW_GAP_EXTEND);
    localparam score_t MATCH = score_t'(`SW_MATCH);
    localparam score_t MISMATCH = score_t'(`SW_MISMATCH);

    logic   valid_q;
    base_t  base_q;
    score_t h_q;
    score_t f_q;
    // E of the previous cell in this row
    score_t row_e;
    // H(i-1, j-1), the top value one step late
    score_t diag_h;

    score_t e_open;
    score_t e_ext;
    score_t e_new;
    score_t f_open;
    score_t f_ext;
    score_t f_new;
    score_t h_diag;
    score_t h_gap;
    score_t h_new;

    always_comb begin
        e_open = h_q + OPEN_EXT;
        e_ext = row_e + EXT;
        e_new = (e_open > e_ext) ? e_open : e_ext;
        f_open = link_in.h + OPEN_EXT;
        f_ext = link_in.f + EXT;
        f_new = (f_open > f_ext) ? f_open : f_ext;
        h_diag = diag_h + ((i_query_base == link_in.base) ? MATCH : MISMATCH);
        h_gap = (e_new > f_new) ? e_new : f_new;
        h_new = (h_diag > h_gap) ? h_diag : h_gap;
    end

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= link_in.valid;
        end
    end

    always_ff @(posedge i_clk) begin
        if (link_in.valid) begin
            h_q <= h_new;
            f_q <= f_new;
            row_e <= e_new;
            base_q <= link_in.base;
        end else begin
            // idle row restarts from the left boundary
            h_q <= i_left_h;
            row_e <= i_left_e;
        end
        diag_h <= link_in.h;
    end

    assign link_out.valid = valid_q;
    assign link_out.base = base_q;
    assign link_out.h = h_q;
    assign link_out.f = f_q;

endmodule

/* hw/sw_max_tree.sv */
`timescale 1ns/1ps
`include "sw_params.svh"

module sw_max_tree import sw_pkg::*; (
    input  score_t                  i_h [`SW_PE_COUNT],
    input  logic [`SW_PE_COUNT-1:0] i_active,
    output score_t                  o_max
);
    localparam int DEPTH = $clog2(`SW_PE_COUNT);
    localparam int LEAVES = 1 << DEPTH;
    localparam score_t NEG_INF = score_t'(`SW_NEG_INF);

    genvar gl, gi;

    generate
        for (gl = 0; gl <= DEPTH; gl++) begin : g_lvl
            score_t node [LEAVES >> gl];

            if (gl == 0) begin : g_leaf
                for (gi = 0; gi < LEAVES; gi++) begin : g_in
                    if (gi < `SW_PE_COUNT) begin : g_pe
                        // idle cells must never win
                        assign node[gi] = i_active[gi] ? i_h[gi] : NEG_INF;
                    end else begin : g_pad
                        assign node[gi] = NEG_INF;
                    end
                end
            end else begin : g_cmp
                for (gi = 0; gi < (LEAVES >> gl); gi++) begin : g_pair
                    assign node[gi] =
                        (g_lvl[gl-1].node[2*gi] > g_lvl[gl-1].node[2*gi+1]) ?
                        g_lvl[gl-1].node[2*gi] : g_lvl[gl-1].node[2*gi+1];
                end
            end
        end
    endgenerate

    assign o_max = g_lvl[DEPTH].node[0];

endmodule

/* hw/sw_pe_array.sv */
`timescale 1ns/1ps
`include "sw_params.svh"

module sw_pe_array import sw_pkg::*; (
    input  logic                    i_clk,
    input  logic                    i_rst,
    input  logic                    i_load,
    input  logic                    i_flush,
    input  logic [`SW_QUERY_W-1:0]  i_query,
    input  logic                    i_ref_valid,
    input  base_t                   i_ref_base,
    output score_t                  o_h [`SW_PE_COUNT],
    output logic [`SW_PE_COUNT-1:0] o_active
);
    localparam score_t OPEN_EXT = score_t'(`SW_GAP_OPEN + `SW_GAP_EXTEND);
    localparam score_t EXT = score_t'(`SW_GAP_EXTEND);
    localparam score_t NEG_INF = score_t'(`SW_NEG_INF);

    logic [`SW_QUERY_W-1:0] query_q;
    logic                   run;
    logic                   feed_valid;
    // H(-1, j) for the next column entering element 0
    score_t                 top_h;

    sw_link_if link [`SW_PE_COUNT+1] ();

    assign feed_valid = i_ref_valid & run;

    // between jobs the feed shows H(-1,-1) = 0 as element 0's diagonal
    assign link[0].valid = feed_valid;
    assign link[0].base = i_ref_base;
    assign link[0].h = feed_valid ? top_h : '0;
    assign link[0].f = NEG_INF;

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            run <= 1'b0;
            o_active <= '0;
        end else begin
            if (i_flush) begin
                run <= 1'b0;
            end else if (i_load) begin
                run <= 1'b1;
            end
            // enable shift register follows the wavefront down the chain
            if (i_flush) begin
                o_active <= '0;
            end else begin
                o_active <= {o_active[`SW_PE_COUNT-2:0], feed_valid};
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_load) begin
            query_q <= i_query;
            top_h <= OPEN_EXT;
        end else if (feed_valid) begin
            top_h <= top_h + EXT;
        end
    end

    genvar gi;

    generate
        for (gi = 0; gi < `SW_PE_COUNT; gi++) begin : g_pe
            // H(i,-1) for row i
            localparam score_t LEFT_H =
                score_t'(`SW_GAP_OPEN + `SW_GAP_EXTEND * (gi + 1));

            sw_pe u_pe (
                .i_clk        (i_clk),
                .i_rst        (i_rst),
                .i_query_base (query_q[2*gi +: 2]),
                .i_left_h     (LEFT_H),
                .i_left_e     (NEG_INF),
                .link_in      (link[gi]),
                .link_out     (link[gi+1])
            );

            assign o_h[gi] = link[gi+1].h;
        end
    endgenerate

endmodule

/* hw/sw_stripe_ctrl.sv */
`timescale 1ns/1ps
`include "sw_params.svh"

module sw_stripe_ctrl import sw_pkg::*; (
    input  logic   i_clk,
    input  logic   i_rst,
    input  logic   i_load,
    input  logic   i_ref_last,
    input  score_t i_diag_max,
    output logic   o_busy,
    output logic   o_done,
    output pos_t   o_end_position,
    output score_t o_max_score,
    output logic   o_flush
);
    localparam score_t NEG_INF = score_t'(`SW_NEG_INF);
    localparam score_t XDROP = score_t'(`SW_XDROP);
    localparam pos_t DRAIN = pos_t'(`SW_PE_COUNT);

    stripe_state_t state;

    // cycles since the first base; the tree shows diagonal step-1
    pos_t   step;
    pos_t   last_step;
    logic   last_seen;
    score_t best;

    score_t best_nxt;
    score_t threshold;
    logic   eval;
    logic   xdrop;
    logic   at_last;

    always_comb begin
        eval = (state == CALC) && (step != '0);
        threshold = best - XDROP;
        best_nxt = (i_diag_max > best) ? i_diag_max : best;
        xdrop = eval && (i_diag_max < threshold);
        at_last = eval && last_seen && (step == last_step);
    end

    assign o_flush = xdrop | at_last;
    assign o_busy = (state == CALC);
    assign o_done = (state == DONE);
    assign o_max_score = best;

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            state <= IDLE;
            step <= '0;
            last_step <= '0;
            last_seen <= 1'b0;
            best <= NEG_INF;
            o_end_position <= '0;
        end else begin
            case (state)
                IDLE, DONE: begin
                    if (i_load) begin
                        state <= CALC;
                        step <= '0;
                        last_seen <= 1'b0;
                        best <= NEG_INF;
                    end else begin
                        state <= IDLE;
                    end
                end
                CALC: begin
                    step <= step + 1'b1;
                    // final diagonal shows up once the last base has crossed the array
                    if (i_ref_last && !last_seen) begin
                        last_seen <= 1'b1;
                        last_step <= step + DRAIN;
                    end
                    if (eval) begin
                        best <= best_nxt;
                    end
                    if (o_flush) begin
                        state <= DONE;
                        o_end_position <= step - 1'b1;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

/* hw/sw_stripe_top.sv */
`timescale 1ns/1ps
`include "sw_params.svh"

module sw_stripe_top import sw_pkg::*; (
    input  logic                   i_clk,
    input  logic                   i_rst,
    input  logic                   i_load,
    input  logic [`SW_QUERY_W-1:0] i_query,
    input  logic                   i_ref_valid,
    input  base_t                  i_ref_base,
    input  logic                   i_ref_last,
    output logic                   o_busy,
    output logic                   o_done,
    output pos_t                   o_end_position,
    output score_t                 o_max_score
);
    score_t                  pe_h [`SW_PE_COUNT];
    logic [`SW_PE_COUNT-1:0] pe_active;
    score_t                  diag_max;
    logic                    flush;

    sw_pe_array u_sw_pe_array (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_load      (i_load),
        .i_flush     (flush),
        .i_query     (i_query),
        .i_ref_valid (i_ref_valid),
        .i_ref_base  (i_ref_base),
        .o_h         (pe_h),
        .o_active    (pe_active)
    );

    sw_max_tree u_sw_max_tree (
        .i_h      (pe_h),
        .i_active (pe_active),
        .o_max    (diag_max)
    );

    sw_stripe_ctrl u_sw_stripe_ctrl (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_load         (i_load),
        .i_ref_last     (i_ref_last),
        .i_diag_max     (diag_max),
        .o_busy         (o_busy),
        .o_done         (o_done),
        .o_end_position (o_end_position),
        .o_max_score    (o_max_score),
        .o_flush        (flush)
    );

endmodule

/* bench/sw_stripe_sva.sv */
`timescale 1ns/1ps

module sw_stripe_sva import sw_pkg::*; (
    input logic   i_clk,
    input logic   i_rst,
    input logic   i_load,
    input logic   i_ref_valid,
    input logic   i_ref_last,
    input logic   o_busy,
    input logic   o_done,
    input pos_t   o_end_position,
    input score_t o_max_score
);
    int   fail_count = 0;
    logic loaded;
    // result is on the outputs until the next load
    logic holding;

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            loaded <= 1'b0;
            holding <= 1'b0;
        end else begin
            if (i_load) begin
                loaded <= 1'b1;
                holding <= 1'b0;
            end else if (o_done) begin
                holding <= 1'b1;
            end
        end
    end

    a_quiet_after_reset: assert property (@(posedge i_clk) disable iff (i_rst)
        !loaded |-> !o_busy && !o_done)
        else begin
            fail_count++;
            $error("o_busy or o_done high before the first load");
        end

    a_done_pulse: assert property (@(posedge i_clk) disable iff (i_rst)
        o_done |-> $past(o_busy) ##1 !o_done)
        else begin
            fail_count++;
            $error("o_done not a single pulse at the end of a busy job");
        end

    a_result_hold: assert property (@(posedge i_clk) disable iff (i_rst)
        (o_done || holding) && !i_load |=> $stable(o_max_score) && $stable(o_end_position))
        else begin
            fail_count++;
            $error("result changed before the next load");
        end

    a_no_stream_gap: assert property (@(posedge i_clk) disable iff (i_rst)
        i_ref_valid && !i_ref_last |=> i_ref_valid)
        else begin
            fail_count++;
            $error("gap in i_ref_valid before i_ref_last");
        end

endmodule

bind sw_stripe_top sw_stripe_sva u_sw_stripe_sva (
    .i_clk          (i_clk),
    .i_rst          (i_rst),
    .i_load         (i_load),
    .i_ref_valid    (i_ref_valid),
    .i_ref_last     (i_ref_last),
    .o_busy         (o_busy),
    .o_done         (o_done),
    .o_end_position (o_end_position),
    .o_max_score    (o_max_score)
);

/* bench/sw_stripe_tb.sv */
`timescale 1ns/1ps
`include "sw_params.svh"

module sw_stripe_tb import sw_pkg::*; ();
    localparam int N = `SW_PE_COUNT;
    localparam int MAX_L = 64;
    localparam int TIMEOUT = 200;
    localparam int GAP_FIRST = `SW_GAP_OPEN + `SW_GAP_EXTEND;

    logic                   i_clk;
    logic                   i_rst;
    logic                   i_load;
    logic [`SW_QUERY_W-1:0] i_query;
    logic                   i_ref_valid;
    base_t                  i_ref_base;
    logic                   i_ref_last;
    logic                   o_busy;
    logic                   o_done;
    pos_t                   o_end_position;
    score_t                 o_max_score;

    base_t       query [N];
    base_t       refseq [MAX_L];
    logic [31:0] rng;
    logic        hung;
    logic        seen;
    logic        early;
    int          errors;
    int          exp_score;
    int          exp_pos;
    int          got_score;
    int          got_pos;

    sw_stripe_top u_sw_stripe_top (.*);

    initial begin
        i_clk = 1'b0;
        forever #5 i_clk = ~i_clk;
    end

    function automatic int max2(input int a, input int b);
        return (a > b) ? a : b;
    endfunction

    // xorshift32
    function automatic base_t random_base();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng[1:0];
    endfunction

    task automatic check_value(input string name, input int got, input int expv);
        assert (got == expv) else begin
            errors++;
            $display("ERR %s got %h expected %h", name, got[`SW_SCORE_W-1:0],
                expv[`SW_SCORE_W-1:0]);
        end
    endtask

    // Gotoh matrices, then the per anti-diagonal maximum and x-drop
    task automatic compute_expected(input int len);
        int   h [N+1][MAX_L+1];
        int   e [N+1][MAX_L+1];
        int   f [N+1][MAX_L+1];
        int   s;
        int   dmax;
        logic stop;
        // index 0 of each dimension is the boundary
        for (int j = 0; j <= len; j++) begin
            h[0][j] = (j == 0) ? 0 : `SW_GAP_OPEN + `SW_GAP_EXTEND * j;
            f[0][j] = `SW_NEG_INF;
        end
        for (int i = 1; i <= N; i++) begin
            h[i][0] = `SW_GAP_OPEN + `SW_GAP_EXTEND * i;
            e[i][0] = `SW_NEG_INF;
            for (int j = 1; j <= len; j++) begin
                s = (query[i-1] == refseq[j-1]) ? `SW_MATCH : `SW_MISMATCH;
                e[i][j] = max2(h[i][j-1] + GAP_FIRST, e[i][j-1] + `SW_GAP_EXTEND);
                f[i][j] = max2(h[i-1][j] + GAP_FIRST, f[i-1][j] + `SW_GAP_EXTEND);
                h[i][j] = max2(h[i-1][j-1] + s, max2(e[i][j], f[i][j]));
            end
        end
        exp_score = `SW_NEG_INF;
        exp_pos = N + len - 2;
        stop = 1'b0;
        for (int d = 0; d <= N + len - 2 && !stop; d++) begin
            dmax = `SW_NEG_INF;
            for (int i = 0; i < N; i++) begin
                if (d - i >= 0 && d - i < len) begin
                    dmax = max2(dmax, h[i+1][d-i+1]);
                end
            end
            if (dmax < exp_score - `SW_XDROP) begin
                stop = 1'b1;
                exp_pos = d;
            end else begin
                exp_score = max2(exp_score, dmax);
            end
        end
    endtask

    task automatic take_result();
        seen = 1'b1;
        got_score = int'(o_max_score);
        got_pos = int'(o_end_position);
    endtask

    task automatic run_job(input int len);
        int waited;
        if (!hung) begin
            compute_expected(len);
            seen = 1'b0;
            early = 1'b0;
            @(negedge i_clk);
            i_load = 1'b1;
            for (int k = 0; k < N; k++) begin
                i_query[2*k +: 2] = query[k];
            end
            // the whole reference is offered, even after an early stop
            for (int j = 0; j <= len; j++) begin
                @(negedge i_clk);
                i_load = 1'b0;
                if (o_done && !seen) begin
                    take_result();
                    early = (j < len);
                end
                i_ref_valid = (j < len);
                i_ref_base = (j < len) ? refseq[j] : 2'b00;
                i_ref_last = (j == len - 1);
            end
            waited = 0;
            while (!seen && !hung) begin
                if (o_done) begin
                    take_result();
                end else if (waited == TIMEOUT) begin
                    hung = 1'b1;
                    errors++;
                    $display("timeout: o_done did not come within %0d cycles", TIMEOUT);
                end else begin
                    @(negedge i_clk);
                    waited++;
                end
            end
            if (seen) begin
                check_value("o_max_score", got_score, exp_score);
                check_value("o_end_position", got_pos, exp_pos);
            end
        end
    endtask

    initial begin : main
        int len;
        rng = 32'd98;
        errors = 0;
        hung = 1'b0;
        seen = 1'b0;
        early = 1'b0;
        i_rst = 1'b1;
        i_load = 1'b0;
        i_query = '0;
        i_ref_valid = 1'b0;
        i_ref_base = 2'b00;
        i_ref_last = 1'b0;
        repeat (16) @(posedge i_clk);
        @(negedge i_clk);
        i_rst = 1'b0;

        // identical query and reference
        for (int k = 0; k < N; k++) begin
            query[k] = random_base();
            refseq[k] = query[k];
        end
        run_job(N);
        if (seen) begin
            check_value("o_max_score", got_score, N * `SW_MATCH);
            check_value("o_end_position", got_pos, 2 * N - 2);
        end

        repeat (10) begin
            void'(random_base());
            len = 8 + int'(rng % 32'd33);
            for (int k = 0; k < N; k++) begin
                query[k] = random_base();
            end
            // mostly follows the query so some jobs score high
            for (int j = 0; j < len; j++) begin
                refseq[j] = random_base();
                if (rng[7:6] != 2'b00) begin
                    refseq[j] = query[j % N];
                end
            end
            run_job(len);
        end

        // matching prefix, then a mismatch tail long enough for x-drop
        for (int j = 0; j < MAX_L; j++) begin
            refseq[j] = (j < N) ? 2'd0 : 2'd3;
        end
        for (int k = 0; k < N; k++) begin
            query[k] = 2'd0;
        end
        run_job(MAX_L);
        if (seen) begin
            assert (early) else begin
                errors++;
                $display("x-drop job ended only after the reference stream was done");
            end
        end

        // straight after the stopped job
        for (int k = 0; k < N; k++) begin
            query[k] = random_base();
            refseq[k] = query[k];
        end
        run_job(N);

        $display("result errors %0d, protocol errors %0d", errors,
            u_sw_stripe_top.u_sw_stripe_sva.fail_count);
        if (errors == 0 && u_sw_stripe_top.u_sw_stripe_sva.fail_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* sw_stripe_top.f */
+incdir+hw
hw/sw_pkg.sv
hw/sw_link_if.sv
hw/sw_pe.sv
hw/sw_max_tree.sv
hw/sw_pe_array.sv
hw/sw_stripe_ctrl.sv
hw/sw_stripe_top.sv
bench/sw_stripe_sva.sv
bench/sw_stripe_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build with Verilator, run, and look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module sw_stripe_tb \
    -f sw_stripe_top.f \
    && ./obj_dir/Vsw_stripe_tb +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "Simulation completed successfully" sim.log \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }
